// File: chip8_cpu.f
+incdir+verilog
+incdir+verif
verilog/chip8_isa_pkg.sv
verilog/chip8_core_pkg.sv
verilog/chip8_ifs.sv
verilog/chip8_alu.sv
verilog/chip8_regfile.sv
verilog/chip8_pc_stack.sv
verilog/chip8_exec.sv
verilog/chip8_cpu.sv
verif/chip8_cpu_tb.sv

// File: verif/chip8_model.svh
// CHIP-8 reference model and random instruction generator
// Instruction-level view of V registers, PC and return stack

`ifndef CHIP8_MODEL_SVH
`define CHIP8_MODEL_SVH

logic [`CHIP8_DATA_W-1:0] m_v [`CHIP8_REG_N];
logic [`CHIP8_ADDR_W-1:0] m_pc;
logic [`CHIP8_ADDR_W-1:0] m_stack [`CHIP8_STACK_DEPTH];
int                       m_sp;
// Shared by generator and responder delays
integer                   seed;

function automatic void model_reset();
	for (int i = 0; i < `CHIP8_REG_N; i++) begin
		m_v[i] = '0;
	end
	m_pc = `CHIP8_RESET_PC;
	m_sp = 0;
endfunction

// 8xyN group, VF written last so it wins over Vx
function automatic void model_alu(input logic [3:0] x, input logic [3:0] y, input logic [3:0] n);
	logic [7:0] vx;
	logic [7:0] vy;
	logic [8:0] sum;
	logic [7:0] res;
	logic       flag;
	vx   = m_v[x];
	vy   = m_v[y];
	sum  = {1'b0, vx} + {1'b0, vy};
	flag = 1'b0;
	case (n)
		4'h0: res = vy;
		4'h1: res = vx | vy;
		4'h2: res = vx & vy;
		4'h3: res = vx ^ vy;
		4'h4: {flag, res} = sum;
		// Not-borrow flags
		4'h5: {flag, res} = {vx >= vy, vx - vy};
		4'h7: {flag, res} = {vy >= vx, vy - vx};
		// Shifts act on Vx and flag the bit shifted out
		4'h6: {flag, res} = {vx[0], 1'b0, vx[7:1]};
		4'hE: {flag, res} = {vx[7], vx[6:0], 1'b0};
		default: return;
	endcase
	m_v[x] = res;
	if (n >= 4'h4) begin
		m_v[`CHIP8_FLAG_REG] = {7'b0, flag};
	end
endfunction

function automatic void model_exec(input logic [15:0] ins);
	logic [3:0]  x;
	logic [3:0]  y;
	logic [11:0] nnn;
	logic [11:0] next_pc;
	x       = ins[11:8];
	y       = ins[7:4];
	nnn     = ins[11:0];
	next_pc = m_pc + 12'd2;
	case (ins[15:12])
		4'h0: if (ins == 16'h00EE) begin
			m_sp--;
			next_pc = m_stack[m_sp];
		end
		4'h1: next_pc = nnn;
		4'h2: begin
			m_stack[m_sp] = m_pc + 12'd2;
			m_sp++;
			next_pc = nnn;
		end
		4'h3: if (m_v[x] == ins[7:0]) next_pc = m_pc + 12'd4;
		4'h4: if (m_v[x] != ins[7:0]) next_pc = m_pc + 12'd4;
		4'h5: if (ins[3:0] == 4'h0 && m_v[x] == m_v[y]) next_pc = m_pc + 12'd4;
		4'h6: m_v[x] = ins[7:0];
		4'h7: m_v[x] = m_v[x] + ins[7:0];
		4'h8: model_alu(x, y, ins[3:0]);
		4'h9: if (ins[3:0] == 4'h0 && m_v[x] != m_v[y]) next_pc = m_pc + 12'd4;
		// Target wraps at 12 bits
		4'hB: next_pc = nnn + {4'h0, m_v[0]};
		default: ;
	endcase
	m_pc = next_pc;
endfunction

// Random instruction, roughly one in ten unsupported
function automatic logic [15:0] gen_instr();
	logic [31:0] r;
	int          sel;
	logic [3:0]  x;
	logic [3:0]  n;
	logic [7:0]  kk;
	logic [15:0] ins;
	r   = $random(seed);
	sel = $unsigned($random(seed)) % 20;
	x   = r[11:8];
	n   = r[19:16] % 9;
	if (n == 4'h8) n = 4'hE;
	// Half the compares use the live register value so skips get taken
	kk  = r[20] ? m_v[x] : r[7:0];
	case (sel)
		0, 1: case (r[13:12])
			2'd0: ins = (r[11:0] == 12'h0EE) ? 16'h00E0 : {4'h0, r[11:0]};
			2'd1: ins = {4'h5, r[11:4], r[3:0] | 4'h1};
			2'd2: ins = {4'h8, r[11:4], 4'h8 + {2'b0, r[1:0]}};
			default: ins = {4'hC + {2'b0, r[15:14]}, r[11:0]};
		endcase
		2: ins = {4'h1, r[11:0]};
		// Stack depth limits calls and returns
		3: ins = (m_sp < `CHIP8_STACK_DEPTH) ? {4'h2, r[11:0]} : {4'h6, r[11:0]};
		4: ins = (m_sp > 0) ? 16'h00EE : {4'h7, r[11:0]};
		5: ins = {4'hB, r[11:0]};
		6, 7: case (r[22:21])
			2'd0: ins = {4'h3, x, kk};
			2'd1: ins = {4'h4, x, kk};
			2'd2: ins = {4'h5, x, r[7:4], 4'h0};
			default: ins = {4'h9, x, r[7:4], 4'h0};
		endcase
		8, 9, 10, 11: ins = {4'h6, r[11:0]};
		12, 13: ins = {4'h7, r[11:0]};
		default: ins = {4'h8, r[11:4], n};
	endcase
	return ins;
endfunction

`endif

// File: verif/chip8_cpu_tb.sv
// CHIP-8 execute core testbench
// Serves random and directed instructions on the fetch port and compares with the model

`include "chip8_consts.svh"

module chip8_cpu_tb;

	localparam int REQ_TIMEOUT  = 50;
	localparam int ACK_TIMEOUT  = 20;
	localparam int RANDOM_COUNT = 300;

	logic                      cpu_clk;
	logic                      rst_n;
	logic                      fetch_req;
	logic [`CHIP8_ADDR_W-1:0]  fetch_addr;
	logic                      fetch_ack;
	logic [`CHIP8_INSTR_W-1:0] fetch_instr;
	logic [`CHIP8_REG_AW-1:0]  dbg_reg_addr;
	logic [`CHIP8_DATA_W-1:0]  dbg_reg_data;

	int   errors;
	int   tests;
	int   failed_tests;
	int   test_start_errors;
	// Set on a timeout so that later steps are skipped
	bit   hung;
	logic [15:0] cf_prog [22];

	`include "chip8_model.svh"

	chip8_cpu u_chip8_cpu (
		.cpu_clk      (cpu_clk),
		.rst_n        (rst_n),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_ack    (fetch_ack),
		.fetch_instr  (fetch_instr),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data)
	);

	initial cpu_clk = 1'b0;
	always #20 cpu_clk = ~cpu_clk;

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// Outputs sampled on the falling edge
	task automatic wait_req(input string name);
		int n;
		if (hung) return;
		n = 0;
		@(negedge cpu_clk);
		while (!fetch_req && n < REQ_TIMEOUT) begin
			@(negedge cpu_clk);
			n++;
		end
		if (!fetch_req) begin
			$display("%s: fetch_req did not rise within %0d cycles", name, REQ_TIMEOUT);
			errors++;
			hung = 1'b1;
		end
	endtask

	// One four-phase transfer with a random ack delay
	task automatic serve_fetch(input string name, input logic [15:0] ins);
		int delay;
		int n;
		wait_req(name);
		if (hung) return;
		check_val({name, " fetch_addr"}, 16'(m_pc), 16'(fetch_addr));
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) begin
			@(negedge cpu_clk);
			assert (fetch_req) else begin
				$display("%s: fetch_req dropped before ack", name);
				errors++;
			end
			check_val({name, " held fetch_addr"}, 16'(m_pc), 16'(fetch_addr));
		end
		@(posedge cpu_clk);
		fetch_instr <= ins;
		fetch_ack   <= 1'b1;
		n = 0;
		@(negedge cpu_clk);
		while (fetch_req && n < ACK_TIMEOUT) begin
			@(negedge cpu_clk);
			n++;
		end
		if (fetch_req) begin
			$display("%s: fetch_req still high %0d cycles after ack", name, ACK_TIMEOUT);
			errors++;
			hung = 1'b1;
		end
		// Junk on the bus once the instruction is latched
		@(posedge cpu_clk);
		fetch_ack   <= 1'b0;
		fetch_instr <= ~ins;
	endtask

	task automatic run_instr(input string name, input logic [15:0] ins);
		serve_fetch(name, ins);
		model_exec(ins);
	endtask

	// Core is idle in st_fetch once fetch_req is back up
	task automatic check_regs(input string name);
		wait_req(name);
		if (hung) return;
		for (int i = 0; i < `CHIP8_REG_N; i++) begin
			@(posedge cpu_clk);
			dbg_reg_addr <= 4'(i);
			@(negedge cpu_clk);
			check_val($sformatf("%s V%0h", name, i), 16'(m_v[i]), 16'(dbg_reg_data));
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [3:0]  fx;
		logic [3:0]  fy;
		logic [3:0]  fn;
		rst_n             = 1'b0;
		fetch_ack         = 1'b0;
		fetch_instr       = '0;
		dbg_reg_addr      = '0;
		seed              = 32'h21c8cedb;
		errors            = 0;
		tests             = 0;
		failed_tests      = 0;
		test_start_errors = 0;
		hung              = 1'b0;
		model_reset();

		// fetch_req stays low through reset and for one cycle after it
		repeat (5) begin
			@(negedge cpu_clk);
			assert (!fetch_req) else begin
				$display("reset: fetch_req high while rst_n is low");
				errors++;
			end
		end
		@(posedge cpu_clk);
		rst_n <= 1'b1;
		@(negedge cpu_clk);
		assert (!fetch_req) else begin
			$display("reset: fetch_req high in the first cycle after reset");
			errors++;
		end
		@(negedge cpu_clk);
		assert (fetch_req) else begin
			$display("reset: fetch_req did not rise in the second cycle after reset");
			errors++;
		end
		wait_req("reset");
		if (!hung) check_val("reset first fetch_addr", 16'(`CHIP8_RESET_PC), 16'(fetch_addr));
		check_regs("reset");
		end_test("reset");

		// Every fetch of the random run checks the handshake and the address
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			run_instr("random", gen_instr());
		end
		check_regs("random");
		end_test("random");

		// Flag ops with random operands where the first pass of each uses x = F
		for (int k = 0; k < 5; k++) begin
			fn = (k == 4) ? 4'hE : 4'(k + 4);
			for (int j = 0; j < 4; j++) begin
				r  = $random(seed);
				fx = (j == 0) ? 4'hF : r[3:0];
				fy = r[7:4];
				run_instr("flags", {4'h6, fx, r[15:8]});
				run_instr("flags", {4'h6, fy, r[23:16]});
				run_instr("flags", {4'h8, fx, fy, fn});
				check_regs("flags");
			end
		end
		end_test("flags");

		// Empty the stack left by the random run before nesting calls
		while (m_sp > 0) begin
			run_instr("control_flow", 16'h00EE);
		end
		cf_prog = '{
			16'h60FF, 16'h61FF, 16'h6212,
			16'hBF80,                          // F80 + FF wraps to 07F
			16'h30FF, 16'h3012, 16'h40FF, 16'h4012,
			16'h5010, 16'h5020, 16'h9020, 16'h9010,
			16'h2300, 16'h2456, 16'h2FFE,      // three nested calls
			16'h00EE, 16'h00EE, 16'h00EE,
			16'h1ABC,
			16'hF007, 16'h00E0, 16'h801F       // unsupported and advance by 2
		};
		foreach (cf_prog[i]) begin
			run_instr("control_flow", cf_prog[i]);
		end
		wait_req("control_flow");
		if (!hung) check_val("control_flow final fetch_addr", 16'(m_pc), 16'(fetch_addr));
		end_test("control_flow");

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: verilog/chip8_cpu.sv
// CHIP-8 execute core top level
// Connects the execute unit, register file and PC stack to plain ports

`include "chip8_consts.svh"

module chip8_cpu (
	input  logic                      cpu_clk,
	input  logic                      rst_n,
	output logic                      fetch_req,
	output logic [`CHIP8_ADDR_W-1:0]  fetch_addr,
	input  logic                      fetch_ack,
	input  logic [`CHIP8_INSTR_W-1:0] fetch_instr,
	input  logic [`CHIP8_REG_AW-1:0]  dbg_reg_addr,
	output logic [`CHIP8_DATA_W-1:0]  dbg_reg_data
);

	chip8_reg_if u_reg_if ();
	chip8_pc_if  u_pc_if ();

	chip8_exec u_exec (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_ack   (fetch_ack),
		.fetch_instr (fetch_instr),
		.rp          (u_reg_if.exec),
		.pcp         (u_pc_if.exec)
	);

	chip8_regfile u_regfile (
		.cpu_clk  (cpu_clk),
		.rst_n    (rst_n),
		.rp       (u_reg_if.regfile),
		.dbg_addr (dbg_reg_addr),
		.dbg_data (dbg_reg_data)
	);

	chip8_pc_stack u_pc_stack (
		.cpu_clk (cpu_clk),
		.rst_n   (rst_n),
		.pcp     (u_pc_if.pc)
	);

endmodule

// File: verilog/chip8_exec.sv
// CHIP-8 execute unit
// Four-phase fetch, decode and single-state execute of the supported instructions

`include "chip8_consts.svh"

module chip8_exec (
	input  logic                      cpu_clk,
	input  logic                      rst_n,
	output logic                      fetch_req,
	output logic [`CHIP8_ADDR_W-1:0]  fetch_addr,
	input  logic                      fetch_ack,
	input  logic [`CHIP8_INSTR_W-1:0] fetch_instr,
	chip8_reg_if.exec                 rp,
	chip8_pc_if.exec                  pcp
);

	chip8_core_pkg::exec_state_e state;
	logic [`CHIP8_INSTR_W-1:0]   instr_q;

	// Instruction fields
	chip8_isa_pkg::reg_idx_t     x, y;
	logic [3:0]                  n;
	chip8_isa_pkg::reg_data_t    kk;
	logic [`CHIP8_ADDR_W-1:0]    nnn;

	chip8_isa_pkg::opcode_e      opcode;
	chip8_isa_pkg::alu_op_e      alu_op;
	chip8_isa_pkg::reg_data_t    alu_b;
	chip8_isa_pkg::reg_data_t    alu_result;
	logic                        alu_flag;
	logic                        take_skip;
	logic                        in_exec;

	// Handshake sequencing
	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			state     <= chip8_core_pkg::st_fetch;
			fetch_req <= 1'b0;
		end else begin
			case (state)
				chip8_core_pkg::st_fetch: begin
					// Request goes up one cycle after reset
					if (!fetch_req) begin
						fetch_req <= 1'b1;
					end else if (fetch_ack) begin
						fetch_req <= 1'b0;
						state     <= chip8_core_pkg::st_release;
					end
				end
				chip8_core_pkg::st_release: begin
					if (!fetch_ack) begin
						state <= chip8_core_pkg::st_execute;
					end
				end
				chip8_core_pkg::st_execute: begin
					// PC updates on this edge and the next request sees the new address
					fetch_req <= 1'b1;
					state     <= chip8_core_pkg::st_fetch;
				end
				default: state <= chip8_core_pkg::st_fetch;
			endcase
		end
	end

	// Latch on the ack edge
	always_ff @(posedge cpu_clk) begin
		if (state == chip8_core_pkg::st_fetch && fetch_req && fetch_ack) begin
			instr_q <= fetch_instr;
		end
	end

	assign fetch_addr = pcp.cur_pc;
	assign in_exec    = (state == chip8_core_pkg::st_execute);

	assign x   = instr_q[11:8];
	assign y   = instr_q[7:4];
	assign n   = instr_q[3:0];
	assign kk  = instr_q[7:0];
	assign nnn = instr_q[11:0];

	// Decode
	always_comb begin
		opcode = chip8_isa_pkg::op_nop;
		alu_op = chip8_isa_pkg::alu_pass;
		case (instr_q[15:12])
			4'h0: if (instr_q == 16'h00EE) opcode = chip8_isa_pkg::op_ret;
			4'h1: opcode = chip8_isa_pkg::op_jp;
			4'h2: opcode = chip8_isa_pkg::op_call;
			4'h3: opcode = chip8_isa_pkg::op_se_imm;
			4'h4: opcode = chip8_isa_pkg::op_sne_imm;
			4'h5: if (n == 4'h0) opcode = chip8_isa_pkg::op_se_reg;
			4'h6: opcode = chip8_isa_pkg::op_ld_imm;
			4'h7: begin
				opcode = chip8_isa_pkg::op_add_imm;
				alu_op = chip8_isa_pkg::alu_add;
			end
			4'h8: begin
				opcode = chip8_isa_pkg::op_alu_flag;
				case (n)
					4'h0: opcode = chip8_isa_pkg::op_alu;
					4'h1: begin
						opcode = chip8_isa_pkg::op_alu;
						alu_op = chip8_isa_pkg::alu_or;
					end
					4'h2: begin
						opcode = chip8_isa_pkg::op_alu;
						alu_op = chip8_isa_pkg::alu_and;
					end
					4'h3: begin
						opcode = chip8_isa_pkg::op_alu;
						alu_op = chip8_isa_pkg::alu_xor;
					end
					4'h4: alu_op = chip8_isa_pkg::alu_add;
					4'h5: alu_op = chip8_isa_pkg::alu_sub;
					4'h6: alu_op = chip8_isa_pkg::alu_shr;
					4'h7: alu_op = chip8_isa_pkg::alu_subn;
					4'hE: alu_op = chip8_isa_pkg::alu_shl;
					default: opcode = chip8_isa_pkg::op_nop;
				endcase
			end
			4'h9: if (n == 4'h0) opcode = chip8_isa_pkg::op_sne_reg;
			4'hB: opcode = chip8_isa_pkg::op_jp_v0;
			default: ;
		endcase
	end

	// Bnnn reads V0 through the x port
	assign rp.rd_addr_x = (opcode == chip8_isa_pkg::op_jp_v0) ? '0 : x;
	assign rp.rd_addr_y = y;

	// Immediate forms take kk as the second operand
	assign alu_b = (opcode == chip8_isa_pkg::op_ld_imm || opcode == chip8_isa_pkg::op_add_imm)
		? kk : rp.rd_data_y;

	chip8_alu u_alu (
		.a      (rp.rd_data_x),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.flag   (alu_flag)
	);

	// Writeback in st_execute only
	assign rp.wr_en = in_exec && (opcode == chip8_isa_pkg::op_ld_imm ||
		opcode == chip8_isa_pkg::op_add_imm || opcode == chip8_isa_pkg::op_alu ||
		opcode == chip8_isa_pkg::op_alu_flag);
	assign rp.wr_addr      = x;
	assign rp.wr_data      = alu_result;
	assign rp.flag_wr_en   = in_exec && (opcode == chip8_isa_pkg::op_alu_flag);
	assign rp.flag_wr_data = alu_flag;

	// Skip conditions
	always_comb begin
		case (opcode)
			chip8_isa_pkg::op_se_imm:  take_skip = (rp.rd_data_x == kk);
			chip8_isa_pkg::op_sne_imm: take_skip = (rp.rd_data_x != kk);
			chip8_isa_pkg::op_se_reg:  take_skip = (rp.rd_data_x == rp.rd_data_y);
			chip8_isa_pkg::op_sne_reg: take_skip = (rp.rd_data_x != rp.rd_data_y);
			default:                   take_skip = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			chip8_isa_pkg::op_jp,
			chip8_isa_pkg::op_jp_v0: pcp.pc_src = chip8_core_pkg::pc_jump;
			chip8_isa_pkg::op_call:  pcp.pc_src = chip8_core_pkg::pc_call;
			chip8_isa_pkg::op_ret:   pcp.pc_src = chip8_core_pkg::pc_ret;
			default: pcp.pc_src = take_skip ? chip8_core_pkg::pc_skip : chip8_core_pkg::pc_next;
		endcase
	end

	// Bnnn target wraps at 12 bits
	assign pcp.target = (opcode == chip8_isa_pkg::op_jp_v0)
		? nnn + {{(`CHIP8_ADDR_W-`CHIP8_DATA_W){1'b0}}, rp.rd_data_x} : nnn;
	assign pcp.advance = in_exec;

	// Back-pressure holds the request address
	a_addr_stable: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		(fetch_req && !fetch_ack) |=> $stable(fetch_addr))
		else $error("fetch_addr changed while waiting for ack");

	// PC moves only once the handshake is fully closed
	a_advance_closed: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		pcp.advance |-> (state == chip8_core_pkg::st_execute && !fetch_req && !fetch_ack))
		else $error("PC advance outside execute or with handshake open");

endmodule

// File: verilog/chip8_pc_stack.sv
// CHIP-8 program counter and return stack
// PC update on advance, 16-entry stack of return addresses

`include "chip8_consts.svh"

module chip8_pc_stack (
	input  logic cpu_clk,
	input  logic rst_n,
	chip8_pc_if.pc pcp
);

	// Pointer counts 0 to DEPTH and the index addresses the entries
	localparam int SP_W  = $clog2(`CHIP8_STACK_DEPTH + 1);
	localparam int IDX_W = $clog2(`CHIP8_STACK_DEPTH);
	localparam logic [`CHIP8_ADDR_W-1:0] STEP_NEXT = 2;
	localparam logic [`CHIP8_ADDR_W-1:0] STEP_SKIP = 4;

	logic [`CHIP8_ADDR_W-1:0] pc_q;
	logic [`CHIP8_ADDR_W-1:0] stack [`CHIP8_STACK_DEPTH];
	logic [SP_W-1:0]          sp;
	logic [IDX_W-1:0]         top_idx;
	logic                     do_call;

	// Entry below the pointer holds the latest return address
	assign top_idx = IDX_W'(sp - 1'b1);
	assign do_call = pcp.advance && (pcp.pc_src == chip8_core_pkg::pc_call);

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			pc_q <= `CHIP8_RESET_PC;
			sp   <= '0;
		end else if (pcp.advance) begin
			case (pcp.pc_src)
				chip8_core_pkg::pc_skip: pc_q <= pc_q + STEP_SKIP;
				chip8_core_pkg::pc_jump: pc_q <= pcp.target;
				chip8_core_pkg::pc_call: begin
					pc_q <= pcp.target;
					sp   <= sp + 1'b1;
				end
				chip8_core_pkg::pc_ret: begin
					pc_q <= stack[top_idx];
					sp   <= sp - 1'b1;
				end
				default: pc_q <= pc_q + STEP_NEXT;
			endcase
		end
	end

	// Return address is the instruction after the call
	always_ff @(posedge cpu_clk) begin
		if (do_call) begin
			stack[sp[IDX_W-1:0]] <= pc_q + STEP_NEXT;
		end
	end

	assign pcp.cur_pc = pc_q;

	// Program must keep calls and returns balanced within the stack depth
	a_no_overflow: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		do_call |-> (sp < `CHIP8_STACK_DEPTH))
		else $error("call with return stack full");

	a_no_underflow: assert property (@(posedge cpu_clk) disable iff (!rst_n)
		(pcp.advance && pcp.pc_src == chip8_core_pkg::pc_ret) |-> (sp != '0))
		else $error("ret with return stack empty");

endmodule

// File: verilog/chip8_regfile.sv
// CHIP-8 V register file
// Sixteen 8-bit registers, two read ports plus a debug read, VF flag write

`include "chip8_consts.svh"

module chip8_regfile (
	input  logic                     cpu_clk,
	input  logic                     rst_n,
	chip8_reg_if.regfile             rp,
	input  chip8_isa_pkg::reg_idx_t  dbg_addr,
	output chip8_isa_pkg::reg_data_t dbg_data
);

	chip8_isa_pkg::reg_data_t regs [`CHIP8_REG_N];

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CHIP8_REG_N; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (rp.wr_en) begin
				regs[rp.wr_addr] <= rp.wr_data;
			end
			// Later assignment, so the flag wins when wr_addr is VF
			if (rp.flag_wr_en) begin
				regs[`CHIP8_FLAG_REG] <= {{(`CHIP8_DATA_W-1){1'b0}}, rp.flag_wr_data};
			end
		end
	end

	// Combinational reads
	assign rp.rd_data_x = regs[rp.rd_addr_x];
	assign rp.rd_data_y = regs[rp.rd_addr_y];
	// Host view of the registers
	assign dbg_data     = regs[dbg_addr];

endmodule

// File: verilog/chip8_alu.sv
// CHIP-8 ALU
// 8-bit logic, add, subtract and shift with VF flag out

`include "chip8_consts.svh"

module chip8_alu (
	input  logic [`CHIP8_DATA_W-1:0] a,
	input  logic [`CHIP8_DATA_W-1:0] b,
	input  chip8_isa_pkg::alu_op_e   op,
	output logic [`CHIP8_DATA_W-1:0] result,
	output logic                     flag
);

	// One extra bit for the carry out
	logic [`CHIP8_DATA_W:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		result = b;
		flag   = 1'b0;
		case (op)
			chip8_isa_pkg::alu_or:  result = a | b;
			chip8_isa_pkg::alu_and: result = a & b;
			chip8_isa_pkg::alu_xor: result = a ^ b;
			chip8_isa_pkg::alu_add: begin
				result = sum[`CHIP8_DATA_W-1:0];
				flag   = sum[`CHIP8_DATA_W];
			end
			// Flag is not-borrow
			chip8_isa_pkg::alu_sub: begin
				result = a - b;
				flag   = (a >= b);
			end
			chip8_isa_pkg::alu_subn: begin
				result = b - a;
				flag   = (b >= a);
			end
			// Shifts act on a, flag takes the bit shifted out
			chip8_isa_pkg::alu_shr: begin
				result = {1'b0, a[`CHIP8_DATA_W-1:1]};
				flag   = a[0];
			end
			chip8_isa_pkg::alu_shl: begin
				result = {a[`CHIP8_DATA_W-2:0], 1'b0};
				flag   = a[`CHIP8_DATA_W-1];
			end
			default: ;  // pass, result is b
		endcase
	end

endmodule

// File: verilog/chip8_ifs.sv
// CHIP-8 internal interfaces
// Register file port bundle and PC control bundle

`include "chip8_consts.svh"

interface chip8_reg_if;

	// Two combinational read ports
	chip8_isa_pkg::reg_idx_t  rd_addr_x;
	chip8_isa_pkg::reg_idx_t  rd_addr_y;
	chip8_isa_pkg::reg_data_t rd_data_x;
	chip8_isa_pkg::reg_data_t rd_data_y;

	// Main write
	logic                     wr_en;
	chip8_isa_pkg::reg_idx_t  wr_addr;
	chip8_isa_pkg::reg_data_t wr_data;

	// VF write lands on the same edge as the main write and wins on VF
	logic                     flag_wr_en;
	logic                     flag_wr_data;

	modport exec (
		output rd_addr_x, rd_addr_y, wr_en, wr_addr, wr_data, flag_wr_en, flag_wr_data,
		input  rd_data_x, rd_data_y
	);

	modport regfile (
		input  rd_addr_x, rd_addr_y, wr_en, wr_addr, wr_data, flag_wr_en, flag_wr_data,
		output rd_data_x, rd_data_y
	);

endinterface

interface chip8_pc_if;

	// One-cycle strobe that qualifies pc_src and target
	logic                           advance;
	chip8_core_pkg::pc_src_e        pc_src;
	logic [`CHIP8_ADDR_W-1:0]       target;
	// Address of the current instruction
	logic [`CHIP8_ADDR_W-1:0]       cur_pc;

	modport exec (output advance, pc_src, target, input cur_pc);

	modport pc (input advance, pc_src, target, output cur_pc);

endinterface

// File: verilog/chip8_core_pkg.sv
// CHIP-8 microarchitecture types
// Execute sequencing states and program counter sources

package chip8_core_pkg;

	// Fetch handshake and execute sequencing
	typedef enum logic [1:0] {
		st_fetch,    // fetch_req raised, waiting for ack
		st_release,  // instruction latched, waiting for ack to drop
		st_execute   // register write and PC update
	} exec_state_e;

	// Next PC selection
	typedef enum logic [2:0] {
		pc_next,  // PC + 2
		pc_skip,  // PC + 4
		pc_jump,  // PC = target
		pc_call,  // push PC + 2, PC = target
		pc_ret    // PC = popped address
	} pc_src_e;

endpackage

// File: verilog/chip8_isa_pkg.sv
// CHIP-8 instruction-set types
// Register index and data types, opcode classes, ALU functions

`include "chip8_consts.svh"

package chip8_isa_pkg;

	typedef logic [`CHIP8_REG_AW-1:0] reg_idx_t;
	typedef logic [`CHIP8_DATA_W-1:0] reg_data_t;

	// Kept instruction classes, anything else decodes to op_nop
	typedef enum logic [3:0] {
		op_nop,
		op_ret,       // 00EE
		op_jp,        // 1nnn
		op_call,      // 2nnn
		op_se_imm,    // 3xkk
		op_sne_imm,   // 4xkk
		op_se_reg,    // 5xy0
		op_ld_imm,    // 6xkk
		op_add_imm,   // 7xkk
		op_alu,       // 8xy0 to 8xy3, no flag
		op_alu_flag,  // 8xy4 to 8xy7, 8xyE
		op_sne_reg,   // 9xy0
		op_jp_v0      // Bnnn
	} opcode_e;

	typedef enum logic [3:0] {
		alu_pass, alu_or, alu_and, alu_xor, alu_add,
		alu_sub, alu_subn, alu_shr, alu_shl
	} alu_op_e;

endpackage

// File: verilog/chip8_consts.svh
// CHIP-8 core constants
// Widths, sizes and reset values shared by the RTL

`ifndef CHIP8_CONSTS_SVH
`define CHIP8_CONSTS_SVH

// Program address width
`define CHIP8_ADDR_W 12
// V register width
`define CHIP8_DATA_W 8
// Fetched instruction width
`define CHIP8_INSTR_W 16

// V0 to VF
`define CHIP8_REG_N 16
`define CHIP8_REG_AW 4
// VF doubles as carry, borrow and shift-out flag
`define CHIP8_FLAG_REG 15

// Return stack entries
`define CHIP8_STACK_DEPTH 16
// Programs load at 0x200
`define CHIP8_RESET_PC 12'h200

`endif
